// File: hdl/raster_defines.svh
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

// Frame buffer geometry.
`define FB_WIDTH 16
`define FB_HEIGHT 12
`define FB_ADDR_W 8

// Pixels tested per group. FB_WIDTH must be a multiple of it.
`define LANES 4

`define MAX_TRIS 4

// Field widths.
`define COORD_W 4
`define COLOR_W 12

`endif

// File: hdl/raster_pkg.sv
`include "raster_defines.svh"

package raster_pkg;

    typedef logic [`COLOR_W-1:0] color_t;
    typedef logic [`COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Flat shaded, one colour for the whole face.
    typedef struct packed {
        vertex_t a;
        vertex_t b;
        vertex_t c;
        color_t  color;
    } triangle_t;

    typedef enum logic [1:0] {
        IDLE,
        BACKGROUND,
        RASTER,
        DONE
    } frame_state_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_WAIT
    } scan_state_t;

endpackage

// File: hdl/raster_if.sv
`timescale 1ns/10ps

// One pixel group, shared by every lane.
interface span_if;
    import raster_pkg::*;

    logic      valid;
    coord_t    x;
    coord_t    y;
    triangle_t triangle;
    logic      last;

    modport source (
        output valid,
        output x,
        output y,
        output triangle,
        output last
    );

    modport lane (
        input valid,
        input x,
        input y,
        input triangle,
        input last
    );
endinterface

// Result of one lane for one pixel.
interface frag_if;
    import raster_pkg::*;

    logic   valid;
    logic   covered;
    coord_t x;
    coord_t y;
    color_t color;
    logic   last;

    modport lane (output valid, output covered, output x, output y, output color, output last);
    modport merger (input valid, input covered, input x, input y, input color, input last);
endinterface

// File: hdl/background_drawer.sv
`timescale 1ns/10ps
`include "raster_defines.svh"

module background_drawer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  raster_pkg::color_t     bg_color,
    output logic                   write_en,
    output logic [`FB_ADDR_W-1:0]  write_addr,
    output raster_pkg::color_t     write_data,
    output logic                   done
);
    import raster_pkg::*;

    localparam int PIXELS = `FB_WIDTH * `FB_HEIGHT;

    logic                  busy;
    logic [`FB_ADDR_W-1:0] addr;
    logic                  at_end;

    assign at_end = (addr == `FB_ADDR_W'(PIXELS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            addr <= '0;
        end else if (start) begin
            busy <= 1'b1;
            addr <= '0;
        end else if (busy) begin
            if (at_end)
                busy <= 1'b0;
            else
                addr <= addr + 1'b1;
        end
    end

    assign write_en   = busy;
    assign write_addr = addr;
    assign write_data = bg_color;
    assign done       = busy && at_end;

    // The frame FSM only restarts the fill after the previous one is over.
    assert property (@(posedge clk) disable iff (!rstn) busy |-> !start);

endmodule

// File: hdl/span_scanner.sv
`timescale 1ns/10ps
`include "raster_defines.svh"

module span_scanner (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  logic [2:0]             tri_count,
    input  raster_pkg::triangle_t  tris [`MAX_TRIS],
    input  logic                   ready,
    span_if.source                 span
);
    import raster_pkg::*;

    localparam int IDX_W = $clog2(`MAX_TRIS);
    localparam int X_W   = `COORD_W + 1;

    scan_state_t      state;
    logic [IDX_W-1:0] tri_idx;
    triangle_t        cur_tri;
    coord_t           lo_x;
    coord_t           hi_x;
    coord_t           lo_y;
    coord_t           hi_y;
    coord_t           cur_x;
    coord_t           cur_y;
    logic             row_end;
    logic             box_end;
    logic             last_tri;

    function automatic coord_t min3(coord_t p, coord_t q, coord_t r);
        coord_t m;
        m = (p < q) ? p : q;
        return (r < m) ? r : m;
    endfunction

    function automatic coord_t max3(coord_t p, coord_t q, coord_t r);
        coord_t m;
        m = (p > q) ? p : q;
        return (r > m) ? r : m;
    endfunction

    function automatic coord_t clamp(coord_t v, int limit);
        return (int'(v) > limit - 1) ? coord_t'(limit - 1) : v;
    endfunction

    assign cur_tri = tris[tri_idx];

    // Bounding box kept inside the frame, left edge snapped to a group.
    assign lo_x = clamp(min3(cur_tri.a.x, cur_tri.b.x, cur_tri.c.x), `FB_WIDTH)
                  & ~coord_t'(`LANES - 1);
    assign hi_x = clamp(max3(cur_tri.a.x, cur_tri.b.x, cur_tri.c.x), `FB_WIDTH);
    assign lo_y = clamp(min3(cur_tri.a.y, cur_tri.b.y, cur_tri.c.y), `FB_HEIGHT);
    assign hi_y = clamp(max3(cur_tri.a.y, cur_tri.b.y, cur_tri.c.y), `FB_HEIGHT);

    assign row_end  = (X_W'(cur_x) + X_W'(`LANES)) > X_W'(hi_x);
    assign box_end  = row_end && (cur_y == hi_y);
    assign last_tri = (3'(tri_idx) == tri_count - 3'd1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= SCAN_IDLE;
            tri_idx <= '0;
            cur_x   <= '0;
            cur_y   <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (start) begin
                        tri_idx <= '0;
                        state   <= SCAN_WAIT;
                    end
                end
                // Store read settles, then the box origin is taken.
                SCAN_WAIT: begin
                    cur_x <= lo_x;
                    cur_y <= lo_y;
                    state <= SCAN_RUN;
                end
                SCAN_RUN: begin
                    if (ready) begin
                        if (!row_end) begin
                            cur_x <= cur_x + coord_t'(`LANES);
                        end else if (!box_end) begin
                            cur_x <= lo_x;
                            cur_y <= cur_y + 1'b1;
                        end else if (last_tri) begin
                            state <= SCAN_IDLE;
                        end else begin
                            tri_idx <= tri_idx + 1'b1;
                            state   <= SCAN_WAIT;
                        end
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    assign span.valid    = (state == SCAN_RUN) && ready;
    assign span.x        = cur_x;
    assign span.y        = cur_y;
    assign span.triangle = cur_tri;
    assign span.last     = last_tri && box_end;

    assert property (@(posedge clk) disable iff (!rstn)
        span.valid |-> (int'(span.x) + `LANES <= `FB_WIDTH) && (int'(span.y) < `FB_HEIGHT));

endmodule

// File: hdl/coverage_lane.sv
`timescale 1ns/10ps
`include "raster_defines.svh"

module coverage_lane #(
    parameter int lane_id = 0
) (
    input logic   clk,
    input logic   rstn,
    span_if.lane  span,
    frag_if.lane  frag
);
    import raster_pkg::*;

    localparam int PX_W = `COORD_W + 1;

    logic [PX_W-1:0]   px_wide;
    coord_t            px;
    logic signed [11:0] e_ab;
    logic signed [11:0] e_bc;
    logic signed [11:0] e_ca;
    logic signed [11:0] twice_area;
    logic              hit;

    // Signed cross product of (v1 - v0) and (p - v0).
    function automatic logic signed [11:0] edge_fn(vertex_t v0, vertex_t v1,
                                                   coord_t qx, coord_t qy);
        logic signed [11:0] ex;
        logic signed [11:0] ey;
        logic signed [11:0] dx;
        logic signed [11:0] dy;
        ex = 12'(v1.x) - 12'(v0.x);
        ey = 12'(v1.y) - 12'(v0.y);
        dx = 12'(qx) - 12'(v0.x);
        dy = 12'(qy) - 12'(v0.y);
        return ex * dy - ey * dx;
    endfunction

    assign px_wide = {1'b0, span.x} + PX_W'(lane_id);
    assign px      = px_wide[`COORD_W-1:0];

    assign e_ab = edge_fn(span.triangle.a, span.triangle.b, px, span.y);
    assign e_bc = edge_fn(span.triangle.b, span.triangle.c, px, span.y);
    assign e_ca = edge_fn(span.triangle.c, span.triangle.a, px, span.y);

    // Edge sum is constant, zero only for a collinear triangle.
    assign twice_area = e_ab + e_bc + e_ca;
    assign hit = (int'(px_wide) < `FB_WIDTH) && !e_ab[11] && !e_bc[11] && !e_ca[11]
                 && (twice_area != 12'sd0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            frag.valid <= 1'b0;
        else
            frag.valid <= span.valid;
    end

    always_ff @(posedge clk) begin
        frag.covered <= hit;
        frag.x       <= px;
        frag.y       <= span.y;
        frag.color   <= span.triangle.color;
        frag.last    <= span.last;
    end

endmodule

// File: hdl/fragment_merger.sv
`timescale 1ns/10ps
`include "raster_defines.svh"

module fragment_merger (
    input  logic                   clk,
    input  logic                   rstn,
    frag_if.merger                 frags [`LANES],
    output logic                   ready,
    output logic                   write_en,
    output logic [`FB_ADDR_W-1:0]  write_addr,
    output raster_pkg::color_t     write_data,
    output logic                   raster_done
);
    import raster_pkg::*;

    logic [`LANES-1:0] in_valid;
    logic [`LANES-1:0] in_cov;
    coord_t            in_x [`LANES];
    logic              grp_valid;

    logic              buf_full;
    logic              buf_last;
    logic [`LANES-1:0] buf_mask;
    coord_t            buf_x [`LANES];
    coord_t            buf_y;
    color_t            buf_color;

    logic [`LANES-1:0] pick;
    logic [`LANES-1:0] rest;
    logic [`LANES-1:0] rest_after;
    logic [`LANES-1:0] in_rest;
    coord_t            pick_x;
    logic              freeing;

    for (genvar i = 0; i < `LANES; i++) begin : g_unpack
        assign in_valid[i] = frags[i].valid;
        assign in_cov[i]   = frags[i].covered;
        assign in_x[i]     = frags[i].x;
    end

    assign grp_valid = &in_valid;

    // Lowest covered lane goes first.
    assign pick    = buf_mask & (~buf_mask + 1'b1);
    assign rest    = buf_mask & ~pick;
    assign freeing = buf_full && (rest == '0);

    always_comb begin
        pick_x = '0;
        for (int i = 0; i < `LANES; i++) begin
            if (pick[i])
                pick_x = buf_x[i];
        end
    end

    // A group issued now leaves the lanes next cycle, and the buffer
    // must be free by then.
    assign in_rest    = in_cov & (in_cov - 1'b1);
    assign rest_after = rest & (rest - 1'b1);
    assign ready      = grp_valid ? (in_rest == '0) : (!buf_full || rest_after == '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_full    <= 1'b0;
            buf_mask    <= '0;
            raster_done <= 1'b0;
        end else begin
            raster_done <= freeing && buf_last;
            if (grp_valid) begin
                buf_full <= 1'b1;
                buf_mask <= in_cov;
            end else begin
                if (freeing)
                    buf_full <= 1'b0;
                buf_mask <= rest;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grp_valid) begin
            buf_x     <= in_x;
            buf_y     <= frags[0].y;
            buf_color <= frags[0].color;
            buf_last  <= frags[0].last;
        end
    end

    assign write_en   = buf_full && (buf_mask != '0);
    assign write_addr = `FB_ADDR_W'(buf_y) * `FB_ADDR_W'(`FB_WIDTH) + `FB_ADDR_W'(pick_x);
    assign write_data = buf_color;

    assert property (@(posedge clk) disable iff (!rstn)
        write_en |-> int'(write_addr) < `FB_WIDTH * `FB_HEIGHT);

    // Scanner back-pressure keeps the buffer from being overrun.
    assert property (@(posedge clk) disable iff (!rstn)
        grp_valid |-> (!buf_full || freeing));

endmodule

// File: hdl/drawing_manager.sv
`timescale 1ns/10ps
`include "raster_defines.svh"

module drawing_manager (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   draw_start,
    input  logic                   draw_ack,
    input  logic [3:0]             sw,
    input  logic [2:0]             tri_count,
    input  logic                   tri_load,
    input  logic [1:0]             tri_index,
    input  raster_pkg::triangle_t  tri_data,
    output logic                   write_en,
    output logic [`FB_ADDR_W-1:0]  write_addr,
    output raster_pkg::color_t     write_data,
    output logic                   frame_done
);
    import raster_pkg::*;

    frame_state_t state;
    frame_state_t next_state;

    triangle_t tris [`MAX_TRIS];
    color_t    bg_color;
    logic [2:0] count_q;

    logic                  bg_start;
    logic                  bg_en;
    logic [`FB_ADDR_W-1:0] bg_addr;
    color_t                bg_data;
    logic                  bg_done;

    logic                  scan_start;
    logic                  mg_ready;
    logic                  mg_en;
    logic [`FB_ADDR_W-1:0] mg_addr;
    color_t                mg_data;
    logic                  raster_done;

    logic                  mux_en;
    logic [`FB_ADDR_W-1:0] mux_addr;
    color_t                mux_data;

    span_if span_bus ();
    frag_if frag_bus [`LANES] ();

    // Triangle store, written only between frames.
    always_ff @(posedge clk) begin
        if (tri_load && state == IDLE)
            tris[tri_index] <= tri_data;
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && draw_start) begin
            bg_color <= {sw, sw, sw};
            count_q  <= (tri_count > 3'(`MAX_TRIS)) ? 3'(`MAX_TRIS) : tri_count;
        end
    end

    background_drawer u_background (
        .clk        (clk),
        .rstn       (rstn),
        .start      (bg_start),
        .bg_color   (bg_color),
        .write_en   (bg_en),
        .write_addr (bg_addr),
        .write_data (bg_data),
        .done       (bg_done)
    );

    span_scanner u_scanner (
        .clk       (clk),
        .rstn      (rstn),
        .start     (scan_start),
        .tri_count (count_q),
        .tris      (tris),
        .ready     (mg_ready),
        .span      (span_bus)
    );

    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        coverage_lane #(
            .lane_id (i)
        ) u_lane (
            .clk  (clk),
            .rstn (rstn),
            .span (span_bus),
            .frag (frag_bus[i])
        );
    end

    fragment_merger u_merger (
        .clk         (clk),
        .rstn        (rstn),
        .frags       (frag_bus),
        .ready       (mg_ready),
        .write_en    (mg_en),
        .write_addr  (mg_addr),
        .write_data  (mg_data),
        .raster_done (raster_done)
    );

    always_comb begin
        next_state = state;
        bg_start   = 1'b0;
        scan_start = 1'b0;
        mux_en     = 1'b0;
        mux_addr   = bg_addr;
        mux_data   = bg_data;
        case (state)
            IDLE: begin
                if (draw_start) begin
                    bg_start   = 1'b1;
                    next_state = BACKGROUND;
                end
            end
            BACKGROUND: begin
                mux_en = bg_en;
                if (bg_done) begin
                    if (count_q == 3'd0) begin
                        next_state = DONE;
                    end else begin
                        scan_start = 1'b1;
                        next_state = RASTER;
                    end
                end
            end
            RASTER: begin
                mux_en   = mg_en;
                mux_addr = mg_addr;
                mux_data = mg_data;
                if (raster_done)
                    next_state = DONE;
            end
            DONE: begin
                if (draw_ack)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // Write port is registered, so frame_done trails the final write.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= IDLE;
            write_en   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            state      <= next_state;
            write_en   <= mux_en;
            frame_done <= (state == DONE) && !draw_ack;
        end
    end

    always_ff @(posedge clk) begin
        write_addr <= mux_addr;
        write_data <= mux_data;
    end

    assert property (@(posedge clk) disable iff (!rstn) frame_done |-> state == DONE);

endmodule

// File: verification/raster_tb.sv
`timescale 1ns/10ps
`include "raster_defines.svh"

module raster_tb;
    import raster_pkg::*;

    localparam int PIXELS     = `FB_WIDTH * `FB_HEIGHT;
    localparam int STIM_WORDS = 512;

    logic                  clk;
    logic                  rstn;
    logic                  draw_start;
    logic                  draw_ack;
    logic [3:0]            sw;
    logic [2:0]            tri_count;
    logic                  tri_load;
    logic [1:0]            tri_index;
    triangle_t             tri_data;
    logic                  write_en;
    logic [`FB_ADDR_W-1:0] write_addr;
    color_t                write_data;
    logic                  frame_done;

    logic [15:0] stim [STIM_WORDS];
    int          stim_ptr;
    int          budget_cycles;
    int          frame_no;

    // Frame buffer as seen through the write port.
    color_t      model_fb [PIXELS];
    color_t      expect_fb [PIXELS];
    triangle_t   frame_tris [`MAX_TRIS];
    logic [3:0]  frame_sw;
    int          frame_tri_count;
    int          raster_expected;
    int          write_count;
    bit          in_frame;

    drawing_manager dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .draw_start (draw_start),
        .draw_ack   (draw_ack),
        .sw         (sw),
        .tri_count  (tri_count),
        .tri_load   (tri_load),
        .tri_index  (tri_index),
        .tri_data   (tri_data),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic int edge_value(vertex_t v0, vertex_t v1, int px, int py);
        return (int'(v1.x) - int'(v0.x)) * (py - int'(v0.y))
             - (int'(v1.y) - int'(v0.y)) * (px - int'(v0.x));
    endfunction

    // A flat triangle covers nothing.
    function automatic bit covers(triangle_t t, int px, int py);
        if (edge_value(t.a, t.b, int'(t.c.x), int'(t.c.y)) == 0)
            return 1'b0;
        return edge_value(t.a, t.b, px, py) >= 0 && edge_value(t.b, t.c, px, py) >= 0
            && edge_value(t.c, t.a, px, py) >= 0;
    endfunction

    task automatic read_frame();
        frame_sw        = stim[stim_ptr][3:0];
        frame_tri_count = int'(stim[stim_ptr + 1]);
        stim_ptr        = stim_ptr + 2;
        if (frame_tri_count > `MAX_TRIS)
            stop_with_error("a frame in the stimulus file has more triangles than the store");
        for (int t = 0; t < frame_tri_count; t++) begin
            frame_tris[t].a.x   = stim[stim_ptr][3:0];
            frame_tris[t].a.y   = stim[stim_ptr + 1][3:0];
            frame_tris[t].b.x   = stim[stim_ptr + 2][3:0];
            frame_tris[t].b.y   = stim[stim_ptr + 3][3:0];
            frame_tris[t].c.x   = stim[stim_ptr + 4][3:0];
            frame_tris[t].c.y   = stim[stim_ptr + 5][3:0];
            frame_tris[t].color = stim[stim_ptr + 6][`COLOR_W-1:0];
            stim_ptr            = stim_ptr + 7;
        end
    endtask

    // Background first, then triangles in load order.
    task automatic build_expected();
        raster_expected = 0;
        for (int p = 0; p < PIXELS; p++)
            expect_fb[p] = {frame_sw, frame_sw, frame_sw};
        for (int t = 0; t < frame_tri_count; t++) begin
            for (int py = 0; py < `FB_HEIGHT; py++) begin
                for (int px = 0; px < `FB_WIDTH; px++) begin
                    if (covers(frame_tris[t], px, py)) begin
                        expect_fb[py * `FB_WIDTH + px] = frame_tris[t].color;
                        raster_expected++;
                    end
                end
            end
        end
    endtask

    task automatic load_triangles();
        for (int t = 0; t < frame_tri_count; t++) begin
            @(posedge clk);
            tri_load  <= 1'b1;
            tri_index <= 2'(t);
            tri_data  <= frame_tris[t];
        end
        @(posedge clk);
        tri_load <= 1'b0;
    endtask

    task automatic run_frame();
        read_frame();
        build_expected();
        for (int p = 0; p < PIXELS; p++)
            model_fb[p] = 'x;
        load_triangles();
        write_count = 0;
        @(posedge clk);
        draw_start <= 1'b1;
        sw         <= frame_sw;
        tri_count  <= 3'(frame_tri_count);
        in_frame   = 1'b1;
        @(posedge clk);
        draw_start <= 1'b0;
        @(negedge clk);
        while (frame_done !== 1'b1)
            @(negedge clk);
        // Level holds while no acknowledge comes.
        repeat (4) begin
            @(negedge clk);
            compare($sformatf("frame %0d frame_done hold", frame_no), 1, frame_done);
        end
        compare($sformatf("frame %0d write count", frame_no), PIXELS + raster_expected,
                write_count);
        for (int py = 0; py < `FB_HEIGHT; py++) begin
            for (int px = 0; px < `FB_WIDTH; px++) begin
                compare($sformatf("frame %0d pixel (%0d,%0d)", frame_no, px, py),
                        expect_fb[py * `FB_WIDTH + px], model_fb[py * `FB_WIDTH + px]);
            end
        end
        @(posedge clk);
        draw_ack <= 1'b1;
        @(posedge clk);
        draw_ack <= 1'b0;
        @(negedge clk);
        compare($sformatf("frame %0d frame_done after ack", frame_no), 0, frame_done);
        in_frame = 1'b0;
    endtask

    // Write port monitor.
    always @(negedge clk) begin
        if (!in_frame) begin
            compare("write_en between frames", 0, write_en);
            compare("frame_done between frames", 0, frame_done);
        end else begin
            if (write_count > 0 && write_count < PIXELS)
                compare($sformatf("frame %0d background burst", frame_no), 1, write_en);
            if (write_en === 1'b1) begin
                if (write_count < PIXELS) begin
                    compare($sformatf("frame %0d background address", frame_no),
                            write_count, write_addr);
                    compare($sformatf("frame %0d background data", frame_no),
                            {frame_sw, frame_sw, frame_sw}, write_data);
                end
                compare($sformatf("frame %0d write address range", frame_no), 1,
                        write_addr < PIXELS);
                model_fb[write_addr] = write_data;
                write_count++;
            end
        end
    end

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        stop_with_error($sformatf("timeout, the frames did not finish in %0d cycles",
                                  budget_cycles));
    end

    initial begin
        int frame_total;
        int ptr;
        int count;
        int budget;
        rstn            = 1'b0;
        draw_start      = 1'b0;
        draw_ack        = 1'b0;
        sw              = '0;
        tri_count       = '0;
        tri_load        = 1'b0;
        tri_index       = '0;
        tri_data        = '0;
        in_frame        = 1'b0;
        write_count     = 0;
        budget_cycles   = 0;
        frame_no        = 0;
        $readmemh("verification/raster_stim.txt", stim);
        if ($isunknown(stim[0]) || stim[0] == 16'h0)
            stop_with_error("the stimulus file is missing or holds no frames");
        frame_total = int'(stim[0]);
        // Size the watchdog from the frames in the file.
        ptr    = 1;
        budget = 0;
        for (int f = 0; f < frame_total; f++) begin
            count  = int'(stim[ptr + 1]);
            budget = budget + PIXELS * (count + 2) + 100;
            ptr    = ptr + 2 + 7 * count;
        end
        budget_cycles = budget;
        stim_ptr      = 1;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        for (int f = 0; f < frame_total; f++) begin
            frame_no = f;
            run_frame();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// File: verification/raster_stim.txt
// Frame count first. Each frame is a line "sw tri_count" and then one line
// per triangle with ax ay bx by cx cy colour, all in hex.
6
// Single triangle.
5 1
1 1 9 1 1 8 abc
// Two overlapping triangles, the second one wins.
a 2
0 0 c 0 0 b 0f0
4 2 e 2 4 a 00f
// Triangles touching the right, bottom and left edges.
3 2
8 4 f 4 f f e21
0 0 5 0 0 b 4c8
// No triangles.
0 0
// Collinear triangle.
f 1
1 1 5 5 9 9 123
// Full store.
7 4
0 0 7 0 0 5 111
8 0 f 0 8 5 222
0 6 7 6 0 b 333
3 2 d 2 3 a 444

// File: list.f
+incdir+hdl
hdl/raster_pkg.sv
hdl/raster_if.sv
hdl/background_drawer.sv
hdl/span_scanner.sv
hdl/coverage_lane.sv
hdl/fragment_merger.sv
hdl/drawing_manager.sv
verification/raster_tb.sv

// File: Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module raster_tb -f list.f -o raster_sim
	./obj_dir/raster_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
